//--- source/rl_trace_consts.svh
`ifndef RL_TRACE_CONSTS_SVH
`define RL_TRACE_CONSTS_SVH

// architectural registers per register file
`define RL_REG_ELS 32
`define RL_REG_ID_W 5

// global mesh coordinates
`define RL_X_W 7
`define RL_Y_W 6

// cycle counter, latency and latency sum width
`define RL_CTR_W 32

// request count kept per load type
`define RL_CNT_W 16

// int, float and icache
`define RL_TYPE_NUM 3

// one network data word
`define RL_DATA_W 32

`endif

//--- source/rl_trace_pkg.sv
`include "rl_trace_consts.svh"

package rl_trace_pkg;

  // request opcode seen on the outgoing link
  typedef enum logic [1:0] {
    e_rl_remote_load  = 2'd0,
    e_rl_remote_store = 2'd1,
    e_rl_atomic       = 2'd2
  } rl_op_e;

  typedef struct packed {
    logic float_wb;
    logic icache_fetch;
  } rl_load_info_s;

  typedef struct packed {
    logic [`RL_DATA_W-3:0] pad;
    rl_load_info_s         info;
  } rl_load_word_s;

  // stores carry data here, loads carry their attribute flags
  typedef union packed {
    logic [`RL_DATA_W-1:0] store_data;
    rl_load_word_s         load;
  } rl_payload_u;

  typedef struct packed {
    rl_op_e                 op;
    logic [`RL_REG_ID_W-1:0] reg_id;
    logic [`RL_X_W-1:0]     dest_x;
    logic [`RL_Y_W-1:0]     dest_y;
    rl_payload_u            payload;
  } rl_out_packet_s;

  typedef enum logic [1:0] {
    e_rl_return_int_wb   = 2'd0,
    e_rl_return_float_wb = 2'd1,
    e_rl_return_ifetch   = 2'd2,
    e_rl_return_credit   = 2'd3
  } rl_return_type_e;

  typedef enum logic [1:0] {
    e_rl_type_int    = 2'd0,
    e_rl_type_float  = 2'd1,
    e_rl_type_icache = 2'd2
  } rl_load_type_e;

  // state of one outstanding load
  typedef struct packed {
    logic [`RL_CTR_W-1:0] start_cycle;
    logic [`RL_X_W-1:0]   dest_x;
    logic [`RL_Y_W-1:0]   dest_y;
  } rl_status_s;

  typedef struct packed {
    logic [`RL_CTR_W-1:0] start_cycle;
    logic [`RL_CTR_W-1:0] end_cycle;
    logic [`RL_X_W-1:0]   src_x;
    logic [`RL_Y_W-1:0]   src_y;
    logic [`RL_X_W-1:0]   dest_x;
    logic [`RL_Y_W-1:0]   dest_y;
    rl_load_type_e        load_type;
    logic [`RL_CTR_W-1:0] latency;
  } rl_trace_record_s;

  typedef struct packed {
    logic [`RL_CNT_W-1:0] count;
    logic [`RL_CTR_W-1:0] lat_sum;
    logic [`RL_CTR_W-1:0] lat_max;
  } rl_lat_stats_s;

endpackage

//--- source/rl_status_table.sv
`timescale 1ns/1ps
`include "rl_trace_consts.svh"

module rl_status_table (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         out_v_i,
  input  rl_trace_pkg::rl_out_packet_s                 out_packet_i,
  input  logic [`RL_CTR_W-1:0]                         cycle_ctr_i,
  output rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0]   int_status_o,
  output rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0]   float_status_o,
  output rl_trace_pkg::rl_status_s                     icache_status_o
);

  rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0] int_status_r;
  rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0] float_status_r;
  rl_trace_pkg::rl_status_s                   icache_status_r;
  rl_trace_pkg::rl_status_s                   next_status;
  rl_trace_pkg::rl_load_info_s                load_info;

  logic                   is_load;
  logic                   is_amo;
  logic                   int_v;
  logic                   float_v;
  logic                   icache_v;
  logic [`RL_REG_ELS-1:0] int_we;
  logic [`RL_REG_ELS-1:0] float_we;

  // flags only mean something when the op is a load
  assign load_info = out_packet_i.payload.load.info;
  assign is_load   = (out_packet_i.op == rl_trace_pkg::e_rl_remote_load);
  assign is_amo    = (out_packet_i.op == rl_trace_pkg::e_rl_atomic);

  // atomics write back an int register, so they share the int slots
  assign int_v = out_v_i
    & ((is_load & ~load_info.float_wb & ~load_info.icache_fetch) | is_amo);
  assign float_v  = out_v_i & is_load & load_info.float_wb;
  assign icache_v = out_v_i & is_load & load_info.icache_fetch;

  // one-hot slot select from the destination register
  assign int_we   = int_v ? (`RL_REG_ELS'(1) << out_packet_i.reg_id) : '0;
  assign float_we = float_v ? (`RL_REG_ELS'(1) << out_packet_i.reg_id) : '0;

  assign next_status = '{
    start_cycle: cycle_ctr_i,
    dest_x:      out_packet_i.dest_x,
    dest_y:      out_packet_i.dest_y
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_status_r    <= '0;
      float_status_r  <= '0;
      icache_status_r <= '0;
    end else begin
      for (int i = 0; i < `RL_REG_ELS; i++) begin
        if (int_we[i]) begin
          int_status_r[i] <= next_status;
        end
        if (float_we[i]) begin
          float_status_r[i] <= next_status;
        end
      end
      // single fetch in flight per tile
      if (icache_v) begin
        icache_status_r <= next_status;
      end
    end
  end

  assign int_status_o    = int_status_r;
  assign float_status_o  = float_status_r;
  assign icache_status_o = icache_status_r;

  // the core never marks a load as both float writeback and icache fetch
  a_load_flags_exclusive: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (out_v_i && is_load) |-> !(load_info.float_wb && load_info.icache_fetch)
  ) else $error("remote load with both float_wb and icache_fetch set");

endmodule

//--- source/rl_return_matcher.sv
`timescale 1ns/1ps
`include "rl_trace_consts.svh"

module rl_return_matcher (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       returned_v_i,
  input  logic                                       returned_yumi_i,
  input  logic [`RL_REG_ID_W-1:0]                    returned_reg_id_i,
  input  rl_trace_pkg::rl_return_type_e              returned_type_i,
  input  logic                                       trace_en_i,
  input  logic [`RL_CTR_W-1:0]                       cycle_ctr_i,
  input  logic [`RL_X_W-1:0]                         tile_x_i,
  input  logic [`RL_Y_W-1:0]                         tile_y_i,
  input  rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0] int_status_i,
  input  rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0] float_status_i,
  input  rl_trace_pkg::rl_status_s                   icache_status_i,
  output logic                                       record_v_o,
  output rl_trace_pkg::rl_trace_record_s             record_o
);

  rl_trace_pkg::rl_status_s       sel_status;
  rl_trace_pkg::rl_load_type_e    sel_type;
  rl_trace_pkg::rl_trace_record_s record_next;
  rl_trace_pkg::rl_trace_record_s record_r;

  logic accept;
  logic record_fire;
  logic record_v_r;

  assign accept = returned_v_i & returned_yumi_i;

  // credits acknowledge stores and have no slot behind them
  assign record_fire = accept & trace_en_i
    & (returned_type_i != rl_trace_pkg::e_rl_return_credit);

  always_comb begin
    sel_status = int_status_i[returned_reg_id_i];
    sel_type   = rl_trace_pkg::e_rl_type_int;
    case (returned_type_i)
      rl_trace_pkg::e_rl_return_float_wb: begin
        sel_status = float_status_i[returned_reg_id_i];
        sel_type   = rl_trace_pkg::e_rl_type_float;
      end
      rl_trace_pkg::e_rl_return_ifetch: begin
        sel_status = icache_status_i;
        sel_type   = rl_trace_pkg::e_rl_type_icache;
      end
      default: begin
      end
    endcase
  end

  assign record_next = '{
    start_cycle: sel_status.start_cycle,
    end_cycle:   cycle_ctr_i,
    src_x:       tile_x_i,
    src_y:       tile_y_i,
    dest_x:      sel_status.dest_x,
    dest_y:      sel_status.dest_y,
    load_type:   sel_type,
    latency:     cycle_ctr_i - sel_status.start_cycle
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      record_v_r <= 1'b0;
    end else begin
      record_v_r <= record_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (record_fire) begin
      record_r <= record_next;
    end
  end

  assign record_v_o = record_v_r;
  assign record_o   = record_r;

  // the core only consumes a response that the network is offering
  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (reset_i)
    returned_yumi_i |-> returned_v_i
  ) else $error("returned_yumi_i high without returned_v_i");

endmodule

//--- source/rl_latency_stats.sv
`timescale 1ns/1ps
`include "rl_trace_consts.svh"

module rl_latency_stats (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          record_v_i,
  input  rl_trace_pkg::rl_trace_record_s                record_i,
  output rl_trace_pkg::rl_lat_stats_s [`RL_TYPE_NUM-1:0] stats_o
);

  rl_trace_pkg::rl_lat_stats_s [`RL_TYPE_NUM-1:0] stats_r;
  rl_trace_pkg::rl_lat_stats_s                    cur_stats;
  rl_trace_pkg::rl_lat_stats_s                    next_stats;

  logic [`RL_CTR_W:0] sum_ext;

  // entry belonging to the incoming record
  always_comb begin
    cur_stats = '0;
    for (int t = 0; t < `RL_TYPE_NUM; t++) begin
      if (record_i.load_type == 2'(t)) begin
        cur_stats = stats_r[t];
      end
    end
  end

  assign sum_ext = {1'b0, cur_stats.lat_sum} + {1'b0, record_i.latency};

  always_comb begin
    next_stats = cur_stats;
    // count and sum hold at all ones
    if (cur_stats.count != '1) begin
      next_stats.count = cur_stats.count + 1'b1;
    end
    next_stats.lat_sum = sum_ext[`RL_CTR_W] ? '1 : sum_ext[`RL_CTR_W-1:0];
    if (record_i.latency > cur_stats.lat_max) begin
      next_stats.lat_max = record_i.latency;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stats_r <= '0;
    end else if (record_v_i) begin
      for (int t = 0; t < `RL_TYPE_NUM; t++) begin
        if (record_i.load_type == 2'(t)) begin
          stats_r[t] <= next_stats;
        end
      end
    end
  end

  assign stats_o = stats_r;

  // the max seen one cycle later must cover the record that was just folded in
  a_max_covers_latency: assert property (
    @(posedge clk_i) disable iff (reset_i)
    record_v_i |=>
      (stats_o[$past(record_i.load_type)].lat_max >= $past(record_i.latency))
  ) else $error("latency max below a recorded latency");

endmodule

//--- source/remote_load_tracer.sv
`timescale 1ns/1ps
`include "rl_trace_consts.svh"

module remote_load_tracer (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          out_v_i,
  input  rl_trace_pkg::rl_out_packet_s                  out_packet_i,
  input  logic                                          returned_v_i,
  input  logic                                          returned_yumi_i,
  input  logic [`RL_REG_ID_W-1:0]                       returned_reg_id_i,
  input  rl_trace_pkg::rl_return_type_e                 returned_type_i,
  input  logic [`RL_X_W-1:0]                            tile_x_i,
  input  logic [`RL_Y_W-1:0]                            tile_y_i,
  input  logic                                          trace_en_i,
  output logic                                          record_v_o,
  output rl_trace_pkg::rl_trace_record_s                record_o,
  output rl_trace_pkg::rl_lat_stats_s [`RL_TYPE_NUM-1:0] stats_o
);

  logic [`RL_CTR_W-1:0]                       cycle_ctr;
  rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0] int_status;
  rl_trace_pkg::rl_status_s [`RL_REG_ELS-1:0] float_status;
  rl_trace_pkg::rl_status_s                   icache_status;
  rl_trace_pkg::rl_trace_record_s             record;
  logic                                       record_v;

  // free-running time base that reads zero in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycle_ctr <= '0;
    end else begin
      cycle_ctr <= cycle_ctr + 1'b1;
    end
  end

  rl_status_table rl_status_table_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .out_v_i         (out_v_i),
    .out_packet_i    (out_packet_i),
    .cycle_ctr_i     (cycle_ctr),
    .int_status_o    (int_status),
    .float_status_o  (float_status),
    .icache_status_o (icache_status)
  );

  rl_return_matcher rl_return_matcher_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .returned_v_i      (returned_v_i),
    .returned_yumi_i   (returned_yumi_i),
    .returned_reg_id_i (returned_reg_id_i),
    .returned_type_i   (returned_type_i),
    .trace_en_i        (trace_en_i),
    .cycle_ctr_i       (cycle_ctr),
    .tile_x_i          (tile_x_i),
    .tile_y_i          (tile_y_i),
    .int_status_i      (int_status),
    .float_status_i    (float_status),
    .icache_status_i   (icache_status),
    .record_v_o        (record_v),
    .record_o          (record)
  );

  rl_latency_stats rl_latency_stats_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .record_v_i (record_v),
    .record_i   (record),
    .stats_o    (stats_o)
  );

  assign record_v_o = record_v;
  assign record_o   = record;

endmodule

//--- test/tb_remote_load_tracer.sv
`timescale 1ns/1ps
`include "rl_trace_consts.svh"

module tb_remote_load_tracer;

  localparam int REC_TIMEOUT = 10;

  // one test step with an optional launch and an optional response after delay cycles
  typedef struct {
    string                         name;
    logic                          launch;
    rl_trace_pkg::rl_op_e          op;
    logic                          float_wb;
    logic                          icache_fetch;
    logic [`RL_REG_ID_W-1:0]       reg_id;
    int                            delay;
    logic                          ret;
    rl_trace_pkg::rl_return_type_e ret_type;
    logic                          trace_en;
    logic                          exp_rec;
  } row_s;

  logic                                           clk_i;
  logic                                           reset_i;
  logic                                           out_v_i;
  rl_trace_pkg::rl_out_packet_s                   out_packet_i;
  logic                                           returned_v_i;
  logic                                           returned_yumi_i;
  logic [`RL_REG_ID_W-1:0]                        returned_reg_id_i;
  rl_trace_pkg::rl_return_type_e                  returned_type_i;
  logic [`RL_X_W-1:0]                             tile_x_i;
  logic [`RL_Y_W-1:0]                             tile_y_i;
  logic                                           trace_en_i;
  logic                                           record_v_o;
  rl_trace_pkg::rl_trace_record_s                 record_o;
  rl_trace_pkg::rl_lat_stats_s [`RL_TYPE_NUM-1:0] stats_o;

  row_s                        rows[$];
  rl_trace_pkg::rl_status_s    model_int [`RL_REG_ELS];
  rl_trace_pkg::rl_status_s    model_float [`RL_REG_ELS];
  rl_trace_pkg::rl_status_s    model_icache;
  rl_trace_pkg::rl_lat_stats_s model_stats [`RL_TYPE_NUM];
  logic [`RL_CTR_W-1:0]        tb_cyc;
  int                          errors;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // zero in the first cycle after reset falls
  always @(posedge clk_i) begin
    if (reset_i) begin
      tb_cyc <= '0;
    end else begin
      tb_cyc <= tb_cyc + 1'b1;
    end
  end

  remote_load_tracer remote_load_tracer_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .out_v_i           (out_v_i),
    .out_packet_i      (out_packet_i),
    .returned_v_i      (returned_v_i),
    .returned_yumi_i   (returned_yumi_i),
    .returned_reg_id_i (returned_reg_id_i),
    .returned_type_i   (returned_type_i),
    .tile_x_i          (tile_x_i),
    .tile_y_i          (tile_y_i),
    .trace_en_i        (trace_en_i),
    .record_v_o        (record_v_o),
    .record_o          (record_o),
    .stats_o           (stats_o)
  );

  task automatic add_row(input string name, input logic launch, input rl_trace_pkg::rl_op_e op,
                         input logic fw, input logic ic, input logic [`RL_REG_ID_W-1:0] reg_id,
                         input int delay, input logic ret,
                         input rl_trace_pkg::rl_return_type_e rt, input logic en,
                         input logic exp_rec);
    row_s r;
    r = '{name, launch, op, fw, ic, reg_id, delay, ret, rt, en, exp_rec};
    rows.push_back(r);
  endtask

  task automatic check_record(input string name, input rl_trace_pkg::rl_trace_record_s exp,
                              input rl_trace_pkg::rl_trace_record_s act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_stats(input string name, input rl_trace_pkg::rl_lat_stats_s exp,
                             input rl_trace_pkg::rl_lat_stats_s act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // plain loads and atomics take the int slot, flagged loads the float or icache slot
  task automatic model_launch(input rl_trace_pkg::rl_out_packet_s pkt,
                              input logic [`RL_CTR_W-1:0] cyc);
    rl_trace_pkg::rl_status_s    st;
    rl_trace_pkg::rl_load_info_s info;
    logic                        is_ld;
    st    = '{start_cycle: cyc, dest_x: pkt.dest_x, dest_y: pkt.dest_y};
    info  = pkt.payload.load.info;
    is_ld = (pkt.op == rl_trace_pkg::e_rl_remote_load);
    if ((pkt.op == rl_trace_pkg::e_rl_atomic)
        || (is_ld && !info.float_wb && !info.icache_fetch)) begin
      model_int[pkt.reg_id] = st;
    end else if (is_ld && info.float_wb) begin
      model_float[pkt.reg_id] = st;
    end else if (is_ld && info.icache_fetch) begin
      model_icache = st;
    end
  endtask

  task automatic apply_row(input row_s r);
    rl_trace_pkg::rl_out_packet_s   pkt;
    rl_trace_pkg::rl_status_s       st;
    rl_trace_pkg::rl_load_type_e    lt;
    rl_trace_pkg::rl_trace_record_s exp;
    logic                           got;
    int                             k;
    int                             late;
    if (r.launch) begin
      pkt        = '0;
      pkt.op     = r.op;
      pkt.reg_id = r.reg_id;
      pkt.dest_x = `RL_X_W'($urandom);
      pkt.dest_y = `RL_Y_W'($urandom);
      if (r.op == rl_trace_pkg::e_rl_remote_store) begin
        pkt.payload.store_data = $urandom;
      end else begin
        pkt.payload.load.info.float_wb     = r.float_wb;
        pkt.payload.load.info.icache_fetch = r.icache_fetch;
      end
      model_launch(pkt, tb_cyc);
      out_v_i      = 1'b1;
      out_packet_i = pkt;
      @(negedge clk_i);
      out_v_i = 1'b0;
    end
    if (r.ret) begin
      repeat (r.launch ? r.delay - 1 : r.delay) @(negedge clk_i);
      st = model_int[r.reg_id];
      lt = rl_trace_pkg::e_rl_type_int;
      if (r.ret_type == rl_trace_pkg::e_rl_return_float_wb) begin
        st = model_float[r.reg_id];
        lt = rl_trace_pkg::e_rl_type_float;
      end else if (r.ret_type == rl_trace_pkg::e_rl_return_ifetch) begin
        st = model_icache;
        lt = rl_trace_pkg::e_rl_type_icache;
      end
      exp = '{start_cycle: st.start_cycle, end_cycle: tb_cyc, src_x: tile_x_i, src_y: tile_y_i,
              dest_x: st.dest_x, dest_y: st.dest_y, load_type: lt,
              latency: tb_cyc - st.start_cycle};
      returned_v_i      = 1'b1;
      returned_yumi_i   = 1'b1;
      returned_reg_id_i = r.reg_id;
      returned_type_i   = r.ret_type;
      trace_en_i        = r.trace_en;
      @(negedge clk_i);
      returned_v_i    = 1'b0;
      returned_yumi_i = 1'b0;
      trace_en_i      = 1'b1;
      got  = 1'b0;
      late = 0;
      for (k = 0; k < REC_TIMEOUT && !got; k++) begin
        if (record_v_o) begin
          got = 1'b1;
        end else begin
          late++;
          @(negedge clk_i);
        end
      end
      if (r.exp_rec && !got) begin
        errors++;
        $display("%s: no record arrived within %0d cycles", r.name, REC_TIMEOUT);
      end else if (r.exp_rec) begin
        // the strobe belongs to the cycle right after acceptance
        if (late != 0) begin
          errors++;
          $display("%s: record arrived %0d cycles after the expected cycle", r.name, late);
        end
        check_record(r.name, exp, record_o);
        model_stats[int'(lt)].count   = model_stats[int'(lt)].count + 1'b1;
        model_stats[int'(lt)].lat_sum = model_stats[int'(lt)].lat_sum + exp.latency;
        if (exp.latency > model_stats[int'(lt)].lat_max) begin
          model_stats[int'(lt)].lat_max = exp.latency;
        end
      end else if (got) begin
        errors++;
        $display("%s: a record came out although none was expected", r.name);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h6daa9f06));
    errors            = 0;
    reset_i           = 1'b1;
    out_v_i           = 1'b0;
    out_packet_i      = '0;
    returned_v_i      = 1'b0;
    returned_yumi_i   = 1'b0;
    returned_reg_id_i = '0;
    returned_type_i   = rl_trace_pkg::e_rl_return_int_wb;
    tile_x_i          = `RL_X_W'(5);
    tile_y_i          = `RL_Y_W'(3);
    trace_en_i        = 1'b1;
    model_icache      = '0;
    for (int i = 0; i < `RL_REG_ELS; i++) begin
      model_int[i]   = '0;
      model_float[i] = '0;
    end
    for (int t = 0; t < `RL_TYPE_NUM; t++) begin
      model_stats[t] = '0;
    end

    add_row("int_load", 1'b1, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b0, 5'd1, 6,
            1'b1, rl_trace_pkg::e_rl_return_int_wb, 1'b1, 1'b1);
    // float and int loads share reg 3 while both are outstanding
    add_row("float_load_r3", 1'b1, rl_trace_pkg::e_rl_remote_load, 1'b1, 1'b0, 5'd3, 0,
            1'b0, rl_trace_pkg::e_rl_return_float_wb, 1'b1, 1'b0);
    add_row("int_load_r3", 1'b1, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b0, 5'd3, 4,
            1'b1, rl_trace_pkg::e_rl_return_int_wb, 1'b1, 1'b1);
    add_row("float_ret_r3", 1'b0, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b0, 5'd3, 2,
            1'b1, rl_trace_pkg::e_rl_return_float_wb, 1'b1, 1'b1);
    add_row("icache_fetch", 1'b1, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b1, 5'd0, 9,
            1'b1, rl_trace_pkg::e_rl_return_ifetch, 1'b1, 1'b1);
    add_row("atomic", 1'b1, rl_trace_pkg::e_rl_atomic, 1'b0, 1'b0, 5'd12, 5,
            1'b1, rl_trace_pkg::e_rl_return_int_wb, 1'b1, 1'b1);
    add_row("trace_off", 1'b1, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b0, 5'd9, 3,
            1'b1, rl_trace_pkg::e_rl_return_int_wb, 1'b0, 1'b0);
    // store to a busy int slot answered by a credit
    add_row("int_load_r7", 1'b1, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b0, 5'd7, 0,
            1'b0, rl_trace_pkg::e_rl_return_int_wb, 1'b1, 1'b0);
    add_row("store_r7", 1'b1, rl_trace_pkg::e_rl_remote_store, 1'b0, 1'b0, 5'd7, 2,
            1'b1, rl_trace_pkg::e_rl_return_credit, 1'b1, 1'b0);
    add_row("int_ret_r7", 1'b0, rl_trace_pkg::e_rl_remote_load, 1'b0, 1'b0, 5'd7, 3,
            1'b1, rl_trace_pkg::e_rl_return_int_wb, 1'b1, 1'b1);

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (record_v_o) begin
      errors++;
      $display("record_v_o is high right after reset");
    end
    for (int t = 0; t < `RL_TYPE_NUM; t++) begin
      check_stats($sformatf("reset_stats_type_%0d", t), '0, stats_o[t]);
    end

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    // stats land one edge after the last record strobe
    repeat (2) @(negedge clk_i);
    for (int t = 0; t < `RL_TYPE_NUM; t++) begin
      check_stats($sformatf("final_stats_type_%0d", t), model_stats[t], stats_o[t]);
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+source
source/rl_trace_pkg.sv
source/rl_status_table.sv
source/rl_return_matcher.sv
source/rl_latency_stats.sv
source/remote_load_tracer.sv
test/tb_remote_load_tracer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_remote_load_tracer \
  -o tb_remote_load_tracer_sim

./obj_dir/tb_remote_load_tracer_sim | tee "$LOG"

if grep -qx "sim passed" "$LOG"; then
  echo "simulation PASSED, see $LOG"
  exit 0
else
  echo "simulation FAILED, see $LOG"
  exit 1
fi
